// ==== all.f ====
rv32i_pkg.sv
circular_queue.sv
dispatch_unit.sv
alu_unit.sv
mul_unit.sv
writeback_arbiter.sv
commit_unit.sv
rob_core.sv
tb_rob_core.sv

// ==== tb_rob_core.sv ====
`timescale 1ns/10ps

module tb_rob_core;

    localparam int clk_period = 100;
    localparam int alu_pairs = 3;
    localparam int addi_pairs = 2;
    localparam int mul_pairs = 3;
    // queue holds queue_depth/2 pairs, the commit register one more.
    localparam int fill_pairs = rv32i_pkg::queue_depth / 2 + 1;
    localparam int random_pairs = 40;
    localparam int total_pairs = alu_pairs + addi_pairs + mul_pairs + fill_pairs + 2 +
                                 random_pairs;
    localparam int drain_cycles = 200;

    localparam int ready_high = 0;
    localparam int ready_hold = 1;
    localparam int ready_rand = 2;

    logic clk;
    logic rst;
    logic in_valid;
    logic in_ready;
    rv32i_pkg::instr_u instr0;
    rv32i_pkg::instr_u instr1;
    logic [31:0] a0;
    logic [31:0] b0;
    logic [31:0] a1;
    logic [31:0] b1;
    logic commit_valid;
    logic commit_ready;
    logic [4:0] commit_rd0;
    logic [31:0] commit_result0;
    logic [4:0] commit_rd1;
    logic [31:0] commit_result1;

    int seed;
    int ready_mode;
    int errors;
    int checks;
    int tests_run;
    int tests_failed;

    // expected commits, program order.
    logic [4:0] exp_rd [$];
    logic [31:0] exp_res [$];
    logic [4:0] want_rd;
    logic [31:0] want_res;

    rv32i_pkg::instr_u rand_i0 [random_pairs];
    rv32i_pkg::instr_u rand_i1 [random_pairs];
    logic [31:0] rand_ops [random_pairs][4];

    rob_core i_rob_core (
        .clk            (clk),
        .rst            (rst),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .instr0         (instr0),
        .instr1         (instr1),
        .a0             (a0),
        .b0             (b0),
        .a1             (a1),
        .b1             (b1),
        .commit_valid   (commit_valid),
        .commit_ready   (commit_ready),
        .commit_rd0     (commit_rd0),
        .commit_result0 (commit_result0),
        .commit_rd1     (commit_rd1),
        .commit_result1 (commit_result1)
    );

    always #(clk_period / 2) clk = ~clk;

    //////////////////////////////////////////////////
    // reference model and instruction builders
    //////////////////////////////////////////////////

    function automatic logic [31:0] ref_result(input rv32i_pkg::instr_u ins,
                                               input logic [31:0] a,
                                               input logic [31:0] b);
        logic [31:0] imm;
        logic [31:0] res;
        imm = {{20{ins.i_fields.imm12[11]}}, ins.i_fields.imm12};
        if (ins.i_fields.opcode == rv32i_pkg::opcode_imm) begin
            res = a + imm;
        end else if (ins.r_fields.funct7 == rv32i_pkg::funct7_mul) begin
            res = a * b;
        end else begin
            case (ins.r_fields.funct3)
                rv32i_pkg::funct3_and: res = a & b;
                rv32i_pkg::funct3_or:  res = a | b;
                rv32i_pkg::funct3_xor: res = a ^ b;
                default: res = (ins.r_fields.funct7 == rv32i_pkg::funct7_sub) ? a - b : a + b;
            endcase
        end
        return res;
    endfunction

    function automatic rv32i_pkg::instr_u make_r(input rv32i_pkg::op_e op,
                                                 input logic [4:0] rd);
        rv32i_pkg::instr_u ins;
        ins.r_fields.funct7 = 7'h00;
        ins.r_fields.rs2 = rd ^ 5'h0a;
        ins.r_fields.rs1 = rd ^ 5'h15;
        ins.r_fields.funct3 = rv32i_pkg::funct3_add;
        ins.r_fields.rd = rd;
        ins.r_fields.opcode = rv32i_pkg::opcode_reg;
        case (op)
            rv32i_pkg::op_sub: ins.r_fields.funct7 = rv32i_pkg::funct7_sub;
            rv32i_pkg::op_mul: ins.r_fields.funct7 = rv32i_pkg::funct7_mul;
            rv32i_pkg::op_and: ins.r_fields.funct3 = rv32i_pkg::funct3_and;
            rv32i_pkg::op_or:  ins.r_fields.funct3 = rv32i_pkg::funct3_or;
            rv32i_pkg::op_xor: ins.r_fields.funct3 = rv32i_pkg::funct3_xor;
            default: ;
        endcase
        return ins;
    endfunction

    function automatic rv32i_pkg::instr_u make_i(input logic [11:0] imm,
                                                 input logic [4:0] rd);
        rv32i_pkg::instr_u ins;
        ins.i_fields.imm12 = imm;
        ins.i_fields.rs1 = rd ^ 5'h15;
        ins.i_fields.funct3 = rv32i_pkg::funct3_add;
        ins.i_fields.rd = rd;
        ins.i_fields.opcode = rv32i_pkg::opcode_imm;
        return ins;
    endfunction

    // six r-type kinds plus addi.
    task automatic make_random(output rv32i_pkg::instr_u ins);
        int kind;
        logic [4:0] rd;
        logic [11:0] imm;
        kind = {$random(seed)} % 7;
        rd = $random(seed);
        imm = $random(seed);
        if (kind == 6) begin
            ins = make_i(imm, rd);
        end else begin
            ins = make_r(rv32i_pkg::op_e'(kind), rd);
        end
    endtask

    //////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////

    task automatic check_rd(input string name, input logic [4:0] got, input logic [4:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_result(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    //////////////////////////////////////////////////
    // commit monitor and commit_ready driver
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        if (!rst && commit_valid && commit_ready) begin
            if (exp_rd.size() < 2) begin
                errors++;
                $display("ERROR: a pair committed while none was outstanding");
            end else begin
                want_rd = exp_rd.pop_front();
                want_res = exp_res.pop_front();
                check_rd("commit_rd0", commit_rd0, want_rd);
                check_result("commit_result0", commit_result0, want_res);
                want_rd = exp_rd.pop_front();
                want_res = exp_res.pop_front();
                check_rd("commit_rd1", commit_rd1, want_rd);
                check_result("commit_result1", commit_result1, want_res);
            end
        end
    end

    initial begin
        commit_ready = 1'b0;
        forever begin
            @(posedge clk);
            case (ready_mode)
                ready_hold: commit_ready <= 1'b0;
                ready_rand: commit_ready <= $random(seed);
                default:    commit_ready <= 1'b1;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // drivers
    //////////////////////////////////////////////////

    task automatic send_pair(input rv32i_pkg::instr_u i0, input rv32i_pkg::instr_u i1,
                             input logic [31:0] a0_v, input logic [31:0] b0_v,
                             input logic [31:0] a1_v, input logic [31:0] b1_v);
        @(posedge clk);
        in_valid <= 1'b1;
        instr0 <= i0;
        instr1 <= i1;
        a0 <= a0_v;
        b0 <= b0_v;
        a1 <= a1_v;
        b1 <= b1_v;
        @(posedge clk);
        while (!in_ready) begin
            @(posedge clk);
        end
        in_valid <= 1'b0;
        exp_rd.push_back(i0.r_fields.rd);
        exp_res.push_back(ref_result(i0, a0_v, b0_v));
        exp_rd.push_back(i1.r_fields.rd);
        exp_res.push_back(ref_result(i1, a1_v, b1_v));
    endtask

    // queue size settles by the falling edge.
    task automatic wait_drained(input int max_cycles);
        int n;
        n = 0;
        while (exp_rd.size() != 0 && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        if (exp_rd.size() != 0) begin
            errors++;
            $display("ERROR: %0d results never committed", exp_rd.size());
            exp_rd.delete();
            exp_res.delete();
        end
        @(posedge clk);
    endtask

    task automatic end_test(input string name, input int err_start);
        tests_run++;
        if (errors != err_start) begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - err_start);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    //////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////

    task automatic test_reset;
        int err_start;
        err_start = errors;
        @(posedge clk);
        check_flag("in_ready", in_ready, 1'b1);
        check_flag("commit_valid", commit_valid, 1'b0);
        end_test("reset", err_start);
    endtask

    task automatic test_alu;
        int err_start;
        err_start = errors;
        send_pair(make_r(rv32i_pkg::op_add, 5'd1), make_r(rv32i_pkg::op_sub, 5'd2),
                  32'h0000_1234, 32'h0000_0ff1, 32'h1000_0000, 32'h2000_0001);
        send_pair(make_r(rv32i_pkg::op_and, 5'd3), make_r(rv32i_pkg::op_or, 5'd4),
                  32'hf0f0_a5a5, 32'h3c3c_ffff, 32'h0102_0304, 32'h8000_0010);
        send_pair(make_r(rv32i_pkg::op_xor, 5'd5), make_r(rv32i_pkg::op_add, 5'd31),
                  32'hdead_beef, 32'hffff_0000, 32'hffff_ffff, 32'h0000_0002);
        wait_drained(drain_cycles);
        end_test("alu_pairs", err_start);
    endtask

    task automatic test_addi;
        int err_start;
        err_start = errors;
        // second operand is ignored for addi.
        send_pair(make_i(12'hffb, 5'd7), make_r(rv32i_pkg::op_add, 5'd8),
                  32'd100, 32'hdead_beef, 32'd7, 32'd9);
        send_pair(make_r(rv32i_pkg::op_sub, 5'd9), make_i(12'h800, 5'd10),
                  32'd5, 32'd6, 32'h0000_1000, 32'h1234_5678);
        wait_drained(drain_cycles);
        end_test("addi", err_start);
    endtask

    task automatic test_mul;
        int err_start;
        err_start = errors;
        send_pair(make_r(rv32i_pkg::op_mul, 5'd11), make_r(rv32i_pkg::op_mul, 5'd12),
                  32'h1234_5678, 32'h9abc_def1, 32'hffff_ffff, 32'hffff_ffff);
        send_pair(make_r(rv32i_pkg::op_mul, 5'd13), make_r(rv32i_pkg::op_add, 5'd14),
                  32'h0001_0003, 32'h0002_0005, 32'h0000_0040, 32'h0000_0001);
        send_pair(make_r(rv32i_pkg::op_add, 5'd15), make_r(rv32i_pkg::op_mul, 5'd16),
                  32'h7fff_ffff, 32'h0000_0001, 32'h8000_0001, 32'h0000_00ff);
        wait_drained(drain_cycles);
        end_test("mul_pairs", err_start);
    endtask

    task automatic test_backpressure;
        int err_start;
        int accepted;
        int idle;
        int k;
        bit stop;
        rv32i_pkg::instr_u i0;
        rv32i_pkg::instr_u i1;
        logic [31:0] ops [4];
        err_start = errors;
        accepted = 0;
        stop = 1'b0;
        ready_mode <= ready_hold;
        @(posedge clk);
        while (!stop && accepted < fill_pairs + 2) begin
            idle = 0;
            @(posedge clk);
            while (!in_ready && idle < 20) begin
                @(posedge clk);
                idle++;
            end
            if (!in_ready) begin
                stop = 1'b1;
            end else begin
                make_random(i0);
                make_random(i1);
                for (k = 0; k < 4; k++) begin
                    ops[k] = $random(seed);
                end
                send_pair(i0, i1, ops[0], ops[1], ops[2], ops[3]);
                accepted++;
            end
        end
        if (accepted != fill_pairs) begin
            errors++;
            $display("ERROR: %0d pairs accepted while commit was held, expected %0d",
                     accepted, fill_pairs);
        end
        check_flag("in_ready", in_ready, 1'b0);
        check_flag("commit_valid", commit_valid, 1'b1);
        ready_mode <= ready_high;
        wait_drained(drain_cycles);
        end_test("backpressure", err_start);
    endtask

    task automatic test_random;
        int err_start;
        int i;
        int k;
        err_start = errors;
        for (i = 0; i < random_pairs; i++) begin
            make_random(rand_i0[i]);
            make_random(rand_i1[i]);
            for (k = 0; k < 4; k++) begin
                rand_ops[i][k] = $random(seed);
            end
        end
        ready_mode <= ready_rand;
        for (i = 0; i < random_pairs; i++) begin
            send_pair(rand_i0[i], rand_i1[i], rand_ops[i][0], rand_ops[i][1],
                      rand_ops[i][2], rand_ops[i][3]);
        end
        wait_drained(drain_cycles);
        ready_mode <= ready_high;
        end_test("random", err_start);
    endtask

    //////////////////////////////////////////////////
    // main sequence and watchdog
    //////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        in_valid = 1'b0;
        instr0 = '0;
        instr1 = '0;
        a0 = '0;
        b0 = '0;
        a1 = '0;
        b1 = '0;
        seed = 10;
        ready_mode = ready_high;
        errors = 0;
        checks = 0;
        tests_run = 0;
        tests_failed = 0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        test_reset();
        test_alu();
        test_addi();
        test_mul();
        test_backpressure();
        test_random();
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // forty cycles per pair is far above the slowest path.
    initial begin
        #(total_pairs * 40 * clk_period);
        $display("ERROR: watchdog expired after %0d cycles", total_pairs * 40);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// ==== rob_core.sv ====
`timescale 1ns/10ps

module rob_core (
    input  logic clk,
    input  logic rst,
    input  logic in_valid,
    output logic in_ready,
    input  rv32i_pkg::instr_u instr0,
    input  rv32i_pkg::instr_u instr1,
    input  logic [31:0] a0,
    input  logic [31:0] b0,
    input  logic [31:0] a1,
    input  logic [31:0] b1,
    output logic commit_valid,
    input  logic commit_ready,
    output logic [4:0] commit_rd0,
    output logic [31:0] commit_result0,
    output logic [4:0] commit_rd1,
    output logic [31:0] commit_result1
);

    logic push;
    logic pop;
    logic full;
    logic empty;
    rv32i_pkg::rob_entry_t push0;
    rv32i_pkg::rob_entry_t push1;
    rv32i_pkg::rob_entry_t q_out0;
    rv32i_pkg::rob_entry_t q_out1;
    rv32i_pkg::rob_entry_t peek0;
    rv32i_pkg::rob_entry_t peek1;
    logic [rv32i_pkg::tag_bits-1:0] head_tag;

    //////////////////////////////////////////////////
    // issue and result buses
    //////////////////////////////////////////////////

    logic alu_issue_valid;
    logic alu_issue_ready;
    logic mul_issue_valid;
    logic mul_issue_ready;
    rv32i_pkg::op_e issue_op;
    logic [31:0] issue_a;
    logic [31:0] issue_b;
    logic [rv32i_pkg::tag_bits-1:0] issue_tag;

    logic alu_res_valid;
    logic alu_res_ready;
    logic [rv32i_pkg::tag_bits-1:0] alu_res_tag;
    logic [31:0] alu_res_result;
    logic mul_res_valid;
    logic mul_res_ready;
    logic [rv32i_pkg::tag_bits-1:0] mul_res_tag;
    logic [31:0] mul_res_result;

    logic wb_valid;
    logic [rv32i_pkg::tag_bits-1:0] wb_tag;
    logic [31:0] wb_result;

    dispatch_unit i_dispatch_unit (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .instr0    (instr0),
        .instr1    (instr1),
        .a0        (a0),
        .b0        (b0),
        .a1        (a1),
        .b1        (b1),
        .full      (full),
        .head_tag  (head_tag),
        .push      (push),
        .push0     (push0),
        .push1     (push1),
        .alu_valid (alu_issue_valid),
        .alu_ready (alu_issue_ready),
        .mul_valid (mul_issue_valid),
        .mul_ready (mul_issue_ready),
        .issue_op  (issue_op),
        .issue_a   (issue_a),
        .issue_b   (issue_b),
        .issue_tag (issue_tag)
    );

    alu_unit i_alu_unit (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (alu_issue_valid),
        .issue_ready (alu_issue_ready),
        .op          (issue_op),
        .a           (issue_a),
        .b           (issue_b),
        .tag         (issue_tag),
        .res_valid   (alu_res_valid),
        .res_ready   (alu_res_ready),
        .res_tag     (alu_res_tag),
        .res_result  (alu_res_result)
    );

    mul_unit i_mul_unit (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (mul_issue_valid),
        .issue_ready (mul_issue_ready),
        .a           (issue_a),
        .b           (issue_b),
        .tag         (issue_tag),
        .res_valid   (mul_res_valid),
        .res_ready   (mul_res_ready),
        .res_tag     (mul_res_tag),
        .res_result  (mul_res_result)
    );

    writeback_arbiter i_writeback_arbiter (
        .clk        (clk),
        .rst        (rst),
        .alu_valid  (alu_res_valid),
        .alu_ready  (alu_res_ready),
        .alu_tag    (alu_res_tag),
        .alu_result (alu_res_result),
        .mul_valid  (mul_res_valid),
        .mul_ready  (mul_res_ready),
        .mul_tag    (mul_res_tag),
        .mul_result (mul_res_result),
        .wb_valid   (wb_valid),
        .wb_tag     (wb_tag),
        .wb_result  (wb_result)
    );

    circular_queue i_circular_queue (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .pop       (pop),
        .in0       (push0),
        .in1       (push1),
        .full      (full),
        .empty     (empty),
        .out0      (q_out0),
        .out1      (q_out1),
        .wb_valid  (wb_valid),
        .wb_tag    (wb_tag),
        .wb_result (wb_result),
        .head_tag  (head_tag),
        .peek0     (peek0),
        .peek1     (peek1)
    );

    commit_unit i_commit_unit (
        .clk            (clk),
        .rst            (rst),
        .peek0          (peek0),
        .peek1          (peek1),
        .empty          (empty),
        .pop            (pop),
        .out0           (q_out0),
        .out1           (q_out1),
        .commit_valid   (commit_valid),
        .commit_ready   (commit_ready),
        .commit_rd0     (commit_rd0),
        .commit_result0 (commit_result0),
        .commit_rd1     (commit_rd1),
        .commit_result1 (commit_result1)
    );

endmodule

// ==== commit_unit.sv ====
`timescale 1ns/10ps

module commit_unit (
    input  logic clk,
    input  logic rst,
    input  rv32i_pkg::rob_entry_t peek0,
    input  rv32i_pkg::rob_entry_t peek1,
    input  logic empty,
    output logic pop,
    input  rv32i_pkg::rob_entry_t out0,
    input  rv32i_pkg::rob_entry_t out1,
    output logic commit_valid,
    input  logic commit_ready,
    output logic [4:0] commit_rd0,
    output logic [31:0] commit_result0,
    output logic [4:0] commit_rd1,
    output logic [31:0] commit_result1
);

    // peeks lag the queue by one cycle.
    logic peek_stale;

    assign pop = !commit_valid && !empty && !peek_stale && peek0.done && peek1.done;

    always_ff @(posedge clk) begin
        if (rst) begin
            commit_valid <= 1'b0;
            peek_stale <= 1'b1;
        end else begin
            // tail moved, or the pair was not yet written.
            peek_stale <= pop || empty;
            if (pop) begin
                commit_valid <= 1'b1;
            end else if (commit_ready) begin
                commit_valid <= 1'b0;
            end
        end
    end

    // popped pair stays in the queue output register until taken.
    assign commit_rd0 = out0.rd;
    assign commit_result0 = out0.result;
    assign commit_rd1 = out1.rd;
    assign commit_result1 = out1.result;

endmodule

// ==== writeback_arbiter.sv ====
`timescale 1ns/10ps

module writeback_arbiter (
    input  logic clk,
    input  logic rst,
    input  logic alu_valid,
    output logic alu_ready,
    input  logic [rv32i_pkg::tag_bits-1:0] alu_tag,
    input  logic [31:0] alu_result,
    input  logic mul_valid,
    output logic mul_ready,
    input  logic [rv32i_pkg::tag_bits-1:0] mul_tag,
    input  logic [31:0] mul_result,
    output logic wb_valid,
    output logic [rv32i_pkg::tag_bits-1:0] wb_tag,
    output logic [31:0] wb_result
);

    // set when the multiplier wins the next tie.
    logic prio_mul;
    logic grant_alu;
    logic grant_mul;

    assign grant_alu = alu_valid && (!mul_valid || !prio_mul);
    assign grant_mul = mul_valid && !grant_alu;

    assign alu_ready = grant_alu;
    assign mul_ready = grant_mul;

    assign wb_valid = grant_alu || grant_mul;
    assign wb_tag = grant_mul ? mul_tag : alu_tag;
    assign wb_result = grant_mul ? mul_result : alu_result;

    always_ff @(posedge clk) begin
        if (rst) begin
            prio_mul <= 1'b0;
        end else if (alu_valid && mul_valid) begin
            prio_mul <= !prio_mul;
        end
    end

endmodule

// ==== mul_unit.sv ====
`timescale 1ns/10ps

module mul_unit (
    input  logic clk,
    input  logic rst,
    input  logic issue_valid,
    output logic issue_ready,
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  logic [rv32i_pkg::tag_bits-1:0] tag,
    output logic res_valid,
    input  logic res_ready,
    output logic [rv32i_pkg::tag_bits-1:0] res_tag,
    output logic [31:0] res_result
);

    logic busy;
    logic issue_fire;
    logic [$clog2(rv32i_pkg::mul_cycles)-1:0] step;
    logic [31:0] mcand;
    logic [31:0] mplier;
    logic [31:0] partial;

    assign issue_ready = !busy && (!res_valid || res_ready);
    assign issue_fire = issue_valid && issue_ready;

    // add shifted multiplicand for each of the low 8 multiplier bits.
    always_comb begin
        partial = res_result;
        for (int i = 0; i < 8; i++) begin
            if (mplier[i]) begin
                partial = partial + (mcand << i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            res_valid <= 1'b0;
            step <= '0;
        end else begin
            if (res_ready) begin
                res_valid <= 1'b0;
            end
            if (issue_fire) begin
                busy <= 1'b1;
                step <= '0;
            end else if (busy) begin
                step <= step + 1'b1;
                if (step == rv32i_pkg::mul_cycles - 1) begin
                    busy <= 1'b0;
                    res_valid <= 1'b1;
                end
            end
        end
    end

    // result register doubles as the accumulator.
    always_ff @(posedge clk) begin
        if (issue_fire) begin
            mcand <= a;
            mplier <= b;
            res_tag <= tag;
            res_result <= '0;
        end else if (busy) begin
            mcand <= mcand << 8;
            mplier <= mplier >> 8;
            res_result <= partial;
        end
    end

endmodule

// ==== alu_unit.sv ====
`timescale 1ns/10ps

module alu_unit (
    input  logic clk,
    input  logic rst,
    input  logic issue_valid,
    output logic issue_ready,
    input  rv32i_pkg::op_e op,
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  logic [rv32i_pkg::tag_bits-1:0] tag,
    output logic res_valid,
    input  logic res_ready,
    output logic [rv32i_pkg::tag_bits-1:0] res_tag,
    output logic [31:0] res_result
);

    logic [31:0] value;
    logic issue_fire;

    // free, or draining this cycle.
    assign issue_ready = !res_valid || res_ready;
    assign issue_fire = issue_valid && issue_ready;

    always_comb begin
        case (op)
            rv32i_pkg::op_sub: value = a - b;
            rv32i_pkg::op_and: value = a & b;
            rv32i_pkg::op_or:  value = a | b;
            rv32i_pkg::op_xor: value = a ^ b;
            default:           value = a + b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid <= 1'b0;
        end else if (issue_fire) begin
            res_valid <= 1'b1;
        end else if (res_ready) begin
            res_valid <= 1'b0;
        end
    end

    // hold register.
    always_ff @(posedge clk) begin
        if (issue_fire) begin
            res_tag <= tag;
            res_result <= value;
        end
    end

endmodule

// ==== dispatch_unit.sv ====
`timescale 1ns/10ps

module dispatch_unit (
    input  logic clk,
    input  logic rst,
    input  logic in_valid,
    output logic in_ready,
    input  rv32i_pkg::instr_u instr0,
    input  rv32i_pkg::instr_u instr1,
    input  logic [31:0] a0,
    input  logic [31:0] b0,
    input  logic [31:0] a1,
    input  logic [31:0] b1,
    input  logic full,
    input  logic [rv32i_pkg::tag_bits-1:0] head_tag,
    output logic push,
    output rv32i_pkg::rob_entry_t push0,
    output rv32i_pkg::rob_entry_t push1,
    output logic alu_valid,
    input  logic alu_ready,
    output logic mul_valid,
    input  logic mul_ready,
    output rv32i_pkg::op_e issue_op,
    output logic [31:0] issue_a,
    output logic [31:0] issue_b,
    output logic [rv32i_pkg::tag_bits-1:0] issue_tag
);

    logic busy;
    logic slot;
    logic issue_fire;
    rv32i_pkg::op_e slot_op [2];
    logic [31:0] slot_a [2];
    logic [31:0] slot_b [2];
    logic [rv32i_pkg::tag_bits-1:0] base_tag;

    //////////////////////////////////////////////////
    // decode
    //////////////////////////////////////////////////

    function automatic rv32i_pkg::op_e decode_op(input rv32i_pkg::instr_u ins);
        rv32i_pkg::op_e op;
        logic is_sub;
        op = rv32i_pkg::op_add;
        is_sub = (ins.r_fields.funct7 == rv32i_pkg::funct7_sub);
        // addi falls through as add.
        if (ins.r_fields.opcode == rv32i_pkg::opcode_reg) begin
            if (ins.r_fields.funct7 == rv32i_pkg::funct7_mul) begin
                op = rv32i_pkg::op_mul;
            end else begin
                case (ins.r_fields.funct3)
                    rv32i_pkg::funct3_add: op = is_sub ? rv32i_pkg::op_sub : rv32i_pkg::op_add;
                    rv32i_pkg::funct3_xor: op = rv32i_pkg::op_xor;
                    rv32i_pkg::funct3_or:  op = rv32i_pkg::op_or;
                    rv32i_pkg::funct3_and: op = rv32i_pkg::op_and;
                    default:               op = rv32i_pkg::op_add;
                endcase
            end
        end
        return op;
    endfunction

    // i-type swaps in the sign extended immediate.
    function automatic logic [31:0] decode_b(input rv32i_pkg::instr_u ins,
                                             input logic [31:0] b);
        logic [11:0] imm;
        imm = ins.i_fields.imm12;
        if (ins.i_fields.opcode == rv32i_pkg::opcode_imm) begin
            return {{20{imm[11]}}, imm};
        end
        return b;
    endfunction

    assign in_ready = !full && !busy;
    assign push = in_valid && in_ready;

    always_comb begin
        push0 = '0;
        push1 = '0;
        push0.rd = instr0.r_fields.rd;
        push1.rd = instr1.r_fields.rd;
    end

    //////////////////////////////////////////////////
    // issue sequencer
    //////////////////////////////////////////////////

    assign issue_op = slot_op[slot];
    assign issue_a = slot_a[slot];
    assign issue_b = slot_b[slot];
    assign issue_tag = base_tag + {{(rv32i_pkg::tag_bits-1){1'b0}}, slot};

    assign alu_valid = busy && (issue_op != rv32i_pkg::op_mul);
    assign mul_valid = busy && (issue_op == rv32i_pkg::op_mul);
    assign issue_fire = (alu_valid && alu_ready) || (mul_valid && mul_ready);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            slot <= 1'b0;
        end else if (push) begin
            busy <= 1'b1;
            slot <= 1'b0;
        end else if (issue_fire) begin
            // slot 1 done returns to idle.
            busy <= !slot;
            slot <= !slot;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            slot_op[0] <= decode_op(instr0);
            slot_op[1] <= decode_op(instr1);
            slot_a[0] <= a0;
            slot_a[1] <= a1;
            slot_b[0] <= decode_b(instr0, b0);
            slot_b[1] <= decode_b(instr1, b1);
            base_tag <= head_tag;
        end
    end

endmodule

// ==== circular_queue.sv ====
`timescale 1ns/10ps

module circular_queue (
    input  logic clk,
    input  logic rst,
    input  logic push,
    input  logic pop,
    input  rv32i_pkg::rob_entry_t in0,
    input  rv32i_pkg::rob_entry_t in1,
    output logic full,
    output logic empty,
    output rv32i_pkg::rob_entry_t out0,
    output rv32i_pkg::rob_entry_t out1,
    input  logic wb_valid,
    input  logic [rv32i_pkg::tag_bits-1:0] wb_tag,
    input  logic [31:0] wb_result,
    output logic [rv32i_pkg::tag_bits-1:0] head_tag,
    output rv32i_pkg::rob_entry_t peek0,
    output rv32i_pkg::rob_entry_t peek1
);

    rv32i_pkg::rob_entry_t entries [rv32i_pkg::queue_depth];

    // top bit is the wrap flag.
    logic [rv32i_pkg::tag_bits:0] head;
    logic [rv32i_pkg::tag_bits:0] tail;

    logic [rv32i_pkg::tag_bits-1:0] head_idx;
    logic [rv32i_pkg::tag_bits-1:0] head_idx1;
    logic [rv32i_pkg::tag_bits-1:0] tail_idx;
    logic [rv32i_pkg::tag_bits-1:0] tail_idx1;

    assign head_idx = head[rv32i_pkg::tag_bits-1:0];
    assign tail_idx = tail[rv32i_pkg::tag_bits-1:0];
    assign head_idx1 = head_idx + 1'b1;
    assign tail_idx1 = tail_idx + 1'b1;

    // same slot, different lap means full.
    assign full = (head_idx == tail_idx) &&
                  (head[rv32i_pkg::tag_bits] != tail[rv32i_pkg::tag_bits]);
    assign empty = (head == tail);
    assign head_tag = head_idx;

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
        end else begin
            if (push) begin
                head <= head + 2'd2;
            end
            if (pop) begin
                tail <= tail + 2'd2;
            end
        end
    end

    //////////////////////////////////////////////////
    // storage and read ports
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (push) begin
            entries[head_idx] <= in0;
            entries[head_idx1] <= in1;
        end

        // result bus never targets a free slot.
        if (wb_valid) begin
            entries[wb_tag].done <= 1'b1;
            entries[wb_tag].result <= wb_result;
        end

        if (pop) begin
            out0 <= entries[tail_idx];
            out1 <= entries[tail_idx1];
        end

        // oldest pair, one cycle behind.
        peek0 <= entries[tail_idx];
        peek1 <= entries[tail_idx1];
    end

endmodule

// ==== rv32i_pkg.sv ====
package rv32i_pkg;

    //////////////////////////////////////////////////
    // sizes
    //////////////////////////////////////////////////

    // reorder queue entries, always used as pairs.
    localparam int queue_depth = 8;
    localparam int tag_bits = 3;

    // eight multiplier bits per iteration.
    localparam int mul_cycles = 4;

    //////////////////////////////////////////////////
    // encodings
    //////////////////////////////////////////////////

    localparam logic [6:0] opcode_reg = 7'b0110011;
    localparam logic [6:0] opcode_imm = 7'b0010011;

    localparam logic [2:0] funct3_add = 3'b000;
    localparam logic [2:0] funct3_xor = 3'b100;
    localparam logic [2:0] funct3_or = 3'b110;
    localparam logic [2:0] funct3_and = 3'b111;

    localparam logic [6:0] funct7_sub = 7'b0100000;
    localparam logic [6:0] funct7_mul = 7'b0000001;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } i_type_t;

    // opcode and rd sit in the same bits in both views.
    typedef union packed {
        r_type_t r_fields;
        i_type_t i_fields;
    } instr_u;

    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_mul
    } op_e;

    typedef struct packed {
        logic [4:0] rd;
        logic done;
        logic [31:0] result;
    } rob_entry_t;

endpackage
